// ==== compile.f ====
+incdir+include
rtl/ooo_pkg.sv
rtl/arch_state.sv
rtl/exec_unit.sv
rtl/commit_queue.sv
rtl/ooo_backend_top.sv
verification/ooo_backend_assert.sv
verification/ooo_backend_tb.sv

// ==== verification/ooo_backend_tb.sv ====
`timescale 1ns/1ps
`include "ooo_cfg.svh"

module ooo_backend_tb;
    import ooo_pkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int NPREG        = `OOO_NUM_PHYS_REG;
    localparam int NARCH        = `OOO_NUM_ARCH_REG;
    localparam int MSB          = `OOO_WORD_SIZE - 1;
    localparam int NUM_GROUPS   = 40;
    localparam int GROUP_CYCLES = 8;
    localparam int SEQ_CYCLES   = 16 + NPREG + NUM_GROUPS * GROUP_CYCLES + 4;

    logic                           clk_i;
    logic                           reset_i;
    logic                           dispatch_valid;
    dispatch_t                      dispatch;
    issue_t                         issue;
    logic [$clog2(`OOO_NUM_FU)-1:0] issue_fu;
    preg_t                          issue_rs1;
    preg_t                          issue_rs2;
    logic                           mispredict;
    logic                           rs1_valid;
    word_t                          rs1_data;
    logic                           rs2_valid;
    word_t                          rs2_data;
    flags_t                         flags;
    logic                           commit_valid;
    preg_t                          commit_dest;
    logic                           cq_full;

    // expected values seen by the bound assertions
    logic   armed;
    logic   rd1_chk;
    logic   exp_rs1_valid;
    word_t  exp_rs1_data;
    logic   rd2_chk;
    logic   exp_rs2_valid;
    word_t  exp_rs2_data;
    flags_t exp_flags;
    logic   exp_commit_valid;
    preg_t  exp_commit_dest;

    // architectural model, renamer and free list
    word_t              m_val [NPREG];
    logic [NPREG-1:0]   m_valid;
    preg_t              rename_map [NARCH];
    preg_t              free_q [$];
    flags_t             m_flags;

    ooo_backend_top dut_i
    (
        .clk_i(clk_i), .reset_i(reset_i)
        , .dispatch_valid_i(dispatch_valid), .dispatch_i(dispatch)
        , .issue_i(issue), .issue_fu_i(issue_fu)
        , .issue_rs1_i(issue_rs1), .issue_rs2_i(issue_rs2), .mispredict_i(mispredict)
        , .rs1_valid_o(rs1_valid), .rs1_data_o(rs1_data)
        , .rs2_valid_o(rs2_valid), .rs2_data_o(rs2_data)
        , .flags_o(flags), .commit_valid_o(commit_valid)
        , .commit_dest_o(commit_dest), .cq_full_o(cq_full)
    );

    bind ooo_backend_top ooo_backend_assert u_assert
    (
        .clk_i(clk_i), .reset_i(reset_i)
        , .rs1_valid_i(rs1_valid_o), .rs1_data_i(rs1_data_o)
        , .rs2_valid_i(rs2_valid_o), .rs2_data_i(rs2_data_o)
        , .flags_i(flags_o), .commit_valid_i(commit_valid_o)
        , .commit_dest_i(commit_dest_o), .cq_full_i(cq_full_o)
        , .armed_i(ooo_backend_tb.armed)
        , .rd1_chk_i(ooo_backend_tb.rd1_chk)
        , .exp_rs1_valid_i(ooo_backend_tb.exp_rs1_valid)
        , .exp_rs1_data_i(ooo_backend_tb.exp_rs1_data)
        , .rd2_chk_i(ooo_backend_tb.rd2_chk)
        , .exp_rs2_valid_i(ooo_backend_tb.exp_rs2_valid)
        , .exp_rs2_data_i(ooo_backend_tb.exp_rs2_data)
        , .exp_flags_i(ooo_backend_tb.exp_flags)
        , .exp_commit_valid_i(ooo_backend_tb.exp_commit_valid)
        , .exp_commit_dest_i(ooo_backend_tb.exp_commit_dest)
    );

    initial
    begin
        clk_i = 1'b0;
    end

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "run aborted");
    endtask

    // integer result and flags straight from the operation rules
    task automatic alu_reference(input alu_op_t op, input word_t a, input word_t b,
        output word_t res, output flags_t fl);
        longint exact;

        fl = '0;
        case (op)
            // overflow when the exact signed sum does not fit the word
            ALU_ADD:
            begin
                res        = a + b;
                exact      = longint'($signed(a)) + longint'($signed(b));
                fl[FLAG_C] = res < a;
                fl[FLAG_V] = exact != longint'($signed(res));
            end
            // carry means no borrow
            ALU_SUB:
            begin
                res        = a - b;
                exact      = longint'($signed(a)) - longint'($signed(b));
                fl[FLAG_C] = a >= b;
                fl[FLAG_V] = exact != longint'($signed(res));
            end
            ALU_AND: res = a & b;
            ALU_OR:  res = a | b;
            ALU_XOR: res = a ^ b;
            default: res = a;
        endcase
        fl[FLAG_Z] = (res == '0);
        fl[FLAG_N] = res[MSB];
    endtask

    function automatic flags_t merge_flags(flags_t old, flags_t mask, flags_t val);
        return (old & ~mask) | (val & mask);
    endfunction

    // per-cycle strobes drop unless the caller raises them again
    task automatic next_slot();
        @(posedge clk_i);
        #1;
        dispatch_valid   = 1'b0;
        issue.valid      = 1'b0;
        mispredict       = 1'b0;
        rd1_chk          = 1'b0;
        rd2_chk          = 1'b0;
        exp_commit_valid = 1'b0;
    endtask

    task automatic set_read(input int port, input preg_t r, input logic v, input word_t d);
        if (port == 1)
        begin
            issue_rs1     = r;
            rd1_chk       = 1'b1;
            exp_rs1_valid = v;
            exp_rs1_data  = d;
        end
        else
        begin
            issue_rs2     = r;
            rd2_chk       = 1'b1;
            exp_rs2_valid = v;
            exp_rs2_data  = d;
        end
    endtask

    // slow op on unit 1 then a younger fast op on unit 0
    task automatic run_group(input bit squash);
        int      l0;
        int      l1;
        preg_t   d0;
        preg_t   d1;
        preg_t   o0;
        preg_t   o1;
        preg_t   a0;
        preg_t   b0;
        preg_t   a1;
        preg_t   b1;
        alu_op_t op0;
        alu_op_t op1;
        flags_t  mk0;
        flags_t  mk1;
        flags_t  f0;
        flags_t  f1;
        word_t   r0;
        word_t   r1;

        l0  = $urandom_range(NARCH - 1, 0);
        l1  = (l0 + $urandom_range(NARCH - 1, 1)) % NARCH;
        d0  = free_q.pop_front();
        d1  = free_q.pop_front();
        o0  = rename_map[l0];
        o1  = rename_map[l1];
        a0  = rename_map[$urandom_range(NARCH - 1, 0)];
        b0  = rename_map[$urandom_range(NARCH - 1, 0)];
        a1  = rename_map[$urandom_range(NARCH - 1, 0)];
        b1  = rename_map[$urandom_range(NARCH - 1, 0)];
        op0 = alu_op_t'($urandom_range(5, 0));
        op1 = alu_op_t'($urandom_range(5, 0));
        mk0 = flags_t'($urandom_range(15, 0));
        mk1 = flags_t'($urandom_range(15, 0));
        alu_reference(op0, m_val[a0], m_val[b0], r0, f0);
        alu_reference(op1, m_val[a1], m_val[b1], r1, f1);

        next_slot();
        dispatch_valid = 1'b1;
        dispatch       = '{dest: d0, old_dest: o0};
        issue          = '{valid: 1'b1, op: op0, dest: d0, flag_mask: mk0};
        issue_fu       = 1'b1;
        set_read(1, a0, 1'b1, m_val[a0]);
        set_read(2, b0, 1'b1, m_val[b0]);
        next_slot();
        dispatch_valid = 1'b1;
        dispatch       = '{dest: d1, old_dest: o1};
        issue          = '{valid: 1'b1, op: op1, dest: d1, flag_mask: mk1};
        issue_fu       = 1'b0;
        set_read(1, a1, 1'b1, m_val[a1]);
        set_read(2, b1, 1'b1, m_val[b1]);
        // fast result forwarded while the slow one is still in flight
        next_slot();
        set_read(1, d1, 1'b1, r1);
        set_read(2, d0, 1'b0, '0);
        next_slot();
        set_read(1, d0, 1'b1, r0);
        set_read(2, d1, 1'b1, r1);
        next_slot();
        if (squash)
        begin
            mispredict = 1'b1;
        end
        else
        begin
            exp_commit_valid = 1'b1;
            exp_commit_dest  = d0;
        end
        next_slot();
        if (squash)
        begin
            set_read(1, d0, m_valid[d0], m_val[d0]);
            set_read(2, o0, m_valid[o0], m_val[o0]);
        end
        else
        begin
            m_flags          = merge_flags(m_flags, mk0, f0);
            exp_flags        = m_flags;
            m_valid[o0]      = 1'b0;
            m_valid[d0]      = 1'b1;
            m_val[d0]        = r0;
            rename_map[l0]   = d0;
            free_q.push_back(o0);
            exp_commit_valid = 1'b1;
            exp_commit_dest  = d1;
            set_read(1, o0, m_valid[o0], m_val[o0]);
            set_read(2, d0, m_valid[d0], m_val[d0]);
        end
        next_slot();
        if (squash)
        begin
            set_read(1, d1, m_valid[d1], m_val[d1]);
            set_read(2, o1, m_valid[o1], m_val[o1]);
            free_q.push_back(d0);
            free_q.push_back(d1);
        end
        else
        begin
            m_flags        = merge_flags(m_flags, mk1, f1);
            exp_flags      = m_flags;
            m_valid[o1]    = 1'b0;
            m_valid[d1]    = 1'b1;
            m_val[d1]      = r1;
            rename_map[l1] = d1;
            free_q.push_back(o1);
            set_read(1, o1, m_valid[o1], m_val[o1]);
            set_read(2, d1, m_valid[d1], m_val[d1]);
        end
        // queue stays quiet until the next dispatch
        next_slot();
    endtask

    always @(negedge clk_i)
    begin
        if (dut_i.u_assert.fail_count != 0)
        begin
            abort_run($sformatf("[FAIL] %0d ns: DUT output does not match the model", $time));
        end
    end

    initial
    begin
        #(SEQ_CYCLES * CLK_PERIOD * 4);
        abort_run("timeout: the test sequence did not finish in the expected time");
    end

    initial
    begin
        void'($urandom(56));
        reset_i          = 1'b1;
        dispatch_valid   = 1'b0;
        dispatch         = '0;
        issue            = '0;
        issue_fu         = '0;
        issue_rs1        = '0;
        issue_rs2        = '0;
        mispredict       = 1'b0;
        armed            = 1'b0;
        rd1_chk          = 1'b0;
        rd2_chk          = 1'b0;
        exp_rs1_valid    = 1'b0;
        exp_rs1_data     = '0;
        exp_rs2_valid    = 1'b0;
        exp_rs2_data     = '0;
        exp_flags        = '0;
        exp_commit_valid = 1'b0;
        exp_commit_dest  = '0;
        m_flags          = '0;
        for (int r = 0; r < NPREG; r++)
        begin
            m_val[r]   = '0;
            m_valid[r] = (r < NARCH);
            if (r < NARCH)
            begin
                rename_map[r] = preg_t'(r);
            end
            else
            begin
                free_q.push_back(preg_t'(r));
            end
        end

        repeat (16) @(posedge clk_i);
        #1;
        reset_i = 1'b0;
        armed   = 1'b1;

        // every register straight out of reset
        for (int r = 0; r < NPREG; r++)
        begin
            next_slot();
            set_read(1, preg_t'(r), m_valid[r], m_val[r]);
            set_read(2, preg_t'(NPREG - 1 - r), m_valid[NPREG - 1 - r], m_val[NPREG - 1 - r]);
        end

        for (int g = 0; g < NUM_GROUPS; g++)
        begin
            run_group(g % 5 == 4);
        end
        next_slot();
        next_slot();
        @(negedge clk_i);

        if (dut_i.u_assert.fail_count == 0)
        begin
            $display("=== PASS ===");
            $finish;
        end
        else
        begin
            abort_run($sformatf("[FAIL] %0d ns: assertion failures were recorded", $time));
        end
    end

endmodule

// ==== verification/ooo_backend_assert.sv ====
`timescale 1ns/1ps

module ooo_backend_assert
(
    input  logic              clk_i
    , input  logic            reset_i
    // DUT outputs
    , input  logic            rs1_valid_i
    , input  ooo_pkg::word_t  rs1_data_i
    , input  logic            rs2_valid_i
    , input  ooo_pkg::word_t  rs2_data_i
    , input  ooo_pkg::flags_t flags_i
    , input  logic            commit_valid_i
    , input  ooo_pkg::preg_t  commit_dest_i
    , input  logic            cq_full_i
    // reference model
    , input  logic            armed_i
    , input  logic            rd1_chk_i
    , input  logic            exp_rs1_valid_i
    , input  ooo_pkg::word_t  exp_rs1_data_i
    , input  logic            rd2_chk_i
    , input  logic            exp_rs2_valid_i
    , input  ooo_pkg::word_t  exp_rs2_data_i
    , input  ooo_pkg::flags_t exp_flags_i
    , input  logic            exp_commit_valid_i
    , input  ooo_pkg::preg_t  exp_commit_dest_i
);

    int unsigned fail_count = 0;

    // data only matters when the register is expected valid
    a_read1: assert property (@(posedge clk_i) disable iff (reset_i || !armed_i)
        rd1_chk_i |-> (rs1_valid_i == exp_rs1_valid_i)
            && (!exp_rs1_valid_i || rs1_data_i == exp_rs1_data_i))
        else
        begin
            $error("read port 1 differs from the model");
            fail_count++;
        end

    a_read2: assert property (@(posedge clk_i) disable iff (reset_i || !armed_i)
        rd2_chk_i |-> (rs2_valid_i == exp_rs2_valid_i)
            && (!exp_rs2_valid_i || rs2_data_i == exp_rs2_data_i))
        else
        begin
            $error("read port 2 differs from the model");
            fail_count++;
        end

    a_flags: assert property (@(posedge clk_i) disable iff (reset_i || !armed_i)
        flags_i == exp_flags_i)
        else
        begin
            $error("flags differ from the model");
            fail_count++;
        end

    // retirement timing and program order
    a_commit: assert property (@(posedge clk_i) disable iff (reset_i || !armed_i)
        commit_valid_i == exp_commit_valid_i)
        else
        begin
            $error("commit strobe differs from the model");
            fail_count++;
        end

    a_commit_dest: assert property (@(posedge clk_i) disable iff (reset_i || !armed_i)
        commit_valid_i |-> commit_dest_i == exp_commit_dest_i)
        else
        begin
            $error("committed register differs from the model");
            fail_count++;
        end

    // at most two entries are ever in flight
    a_not_full: assert property (@(posedge clk_i) disable iff (reset_i || !armed_i)
        !cq_full_i)
        else
        begin
            $error("commit queue reports full");
            fail_count++;
        end

endmodule

// ==== rtl/ooo_backend_top.sv ====
`timescale 1ns/1ps
`include "ooo_cfg.svh"

module ooo_backend_top
(
    input  logic                          clk_i
    , input  logic                        reset_i
    , input  logic                        dispatch_valid_i
    , input  ooo_pkg::dispatch_t          dispatch_i
    , input  ooo_pkg::issue_t             issue_i
    , input  logic [$clog2(`OOO_NUM_FU)-1:0] issue_fu_i
    , input  ooo_pkg::preg_t              issue_rs1_i
    , input  ooo_pkg::preg_t              issue_rs2_i
    , input  logic                        mispredict_i
    , output logic                        rs1_valid_o
    , output ooo_pkg::word_t              rs1_data_o
    , output logic                        rs2_valid_o
    , output ooo_pkg::word_t              rs2_data_o
    , output ooo_pkg::flags_t             flags_o
    , output logic                        commit_valid_o
    , output ooo_pkg::preg_t              commit_dest_o
    , output logic                        cq_full_o
);
    import ooo_pkg::*;

    cdb_t      cdb [`OOO_NUM_FU-1:0];
    issue_t    fu_issue [`OOO_NUM_FU-1:0];
    logic      commit_valid;
    preg_t     commit_free;
    preg_t     commit_set;
    logic      flag_valid;
    flag_upd_t flag_upd;
    logic      rollback;

    // steer the issue to the selected unit only
    always_comb
    begin
        for (int i = 0; i < `OOO_NUM_FU; i++)
        begin
            fu_issue[i]       = issue_i;
            fu_issue[i].valid = issue_i.valid && (int'(issue_fu_i) == i);
        end
    end

    assign commit_valid_o = commit_valid;
    assign commit_dest_o  = commit_set;

    arch_state u_state
    (
        .clk_i(clk_i), .reset_i(reset_i), .cdb_i(cdb)
        , .commit_valid_i(commit_valid), .commit_free_i(commit_free)
        , .commit_set_i(commit_set), .rollback_i(rollback)
        , .flag_valid_i(flag_valid), .flag_upd_i(flag_upd), .flags_o(flags_o)
        , .rs1_addr_i(issue_rs1_i), .rs1_valid_o(rs1_valid_o), .rs1_data_o(rs1_data_o)
        , .rs2_addr_i(issue_rs2_i), .rs2_valid_o(rs2_valid_o), .rs2_data_o(rs2_data_o)
    );

    exec_unit #(.LATENCY(1)) u_fu0
    (
        .clk_i(clk_i), .reset_i(reset_i), .issue_i(fu_issue[0])
        , .src1_i(rs1_data_o), .src2_i(rs2_data_o), .cdb_o(cdb[0])
    );

    exec_unit #(.LATENCY(3)) u_fu1
    (
        .clk_i(clk_i), .reset_i(reset_i), .issue_i(fu_issue[1])
        , .src1_i(rs1_data_o), .src2_i(rs2_data_o), .cdb_o(cdb[1])
    );

    commit_queue u_cq
    (
        .clk_i(clk_i), .reset_i(reset_i)
        , .dispatch_valid_i(dispatch_valid_i), .dispatch_i(dispatch_i)
        , .cdb_i(cdb), .mispredict_i(mispredict_i)
        , .commit_valid_o(commit_valid), .commit_free_o(commit_free)
        , .commit_set_o(commit_set), .flag_valid_o(flag_valid)
        , .flag_upd_o(flag_upd), .rollback_o(rollback), .full_o(cq_full_o)
    );

endmodule

// ==== rtl/commit_queue.sv ====
`timescale 1ns/1ps
`include "ooo_cfg.svh"

module commit_queue
(
    input  logic                 clk_i
    , input  logic               reset_i
    , input  logic               dispatch_valid_i
    , input  ooo_pkg::dispatch_t dispatch_i
    , input  ooo_pkg::cdb_t      cdb_i [`OOO_NUM_FU-1:0]
    , input  logic               mispredict_i
    , output logic               commit_valid_o
    , output ooo_pkg::preg_t     commit_free_o
    , output ooo_pkg::preg_t     commit_set_o
    , output logic               flag_valid_o
    , output ooo_pkg::flag_upd_t flag_upd_o
    , output logic               rollback_o
    , output logic               full_o
);
    import ooo_pkg::*;

    localparam int DEPTH = `OOO_CQ_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    dispatch_t        entry_q [DEPTH];
    flag_upd_t        upd_q [DEPTH];
    logic [DEPTH-1:0] vld_q;
    logic [DEPTH-1:0] done_q;
    logic [PTR_W-1:0] head_q;
    logic [PTR_W-1:0] tail_q;
    logic [CNT_W-1:0] count_q;

    logic [DEPTH-1:0] cdb_hit;
    flag_upd_t        cdb_upd [DEPTH];
    logic             disp_hit;
    flag_upd_t        disp_upd;
    logic             push;
    logic             retire;

    // completion snoop for waiting entries and for the slot being filled
    always_comb
    begin
        disp_hit = 1'b0;
        disp_upd = '0;
        for (int e = 0; e < DEPTH; e++)
        begin
            cdb_hit[e] = 1'b0;
            cdb_upd[e] = '0;
        end

        for (int u = 0; u < `OOO_NUM_FU; u++)
        begin
            for (int e = 0; e < DEPTH; e++)
            begin
                if (vld_q[e] && !done_q[e] && cdb_i[u].valid
                    && cdb_i[u].dest == entry_q[e].dest)
                begin
                    cdb_hit[e] = 1'b1;
                    cdb_upd[e] = cdb_i[u].flag_upd;
                end
            end
            if (cdb_i[u].valid && cdb_i[u].dest == dispatch_i.dest)
            begin
                disp_hit = 1'b1;
                disp_upd = cdb_i[u].flag_upd;
            end
        end
    end

    assign full_o = (count_q == CNT_W'(DEPTH));
    assign push   = dispatch_valid_i && !full_o;
    // a mispredict squashes the whole queue, head included
    assign retire = vld_q[head_q] && done_q[head_q] && !mispredict_i;

    assign commit_valid_o = retire;
    assign commit_free_o  = entry_q[head_q].old_dest;
    assign commit_set_o   = entry_q[head_q].dest;
    assign flag_valid_o   = retire;
    assign flag_upd_o     = upd_q[head_q];
    assign rollback_o     = mispredict_i;

    always_ff @(posedge clk_i)
    begin
        if (reset_i || mispredict_i)
        begin
            vld_q   <= '0;
            done_q  <= '0;
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end
        else
        begin
            done_q <= done_q | cdb_hit;
            if (retire)
            begin
                vld_q[head_q]  <= 1'b0;
                done_q[head_q] <= 1'b0;
                head_q <= (head_q == PTR_W'(DEPTH - 1)) ? '0 : head_q + 1'b1;
            end
            if (push)
            begin
                vld_q[tail_q]  <= 1'b1;
                done_q[tail_q] <= disp_hit;
                tail_q <= (tail_q == PTR_W'(DEPTH - 1)) ? '0 : tail_q + 1'b1;
            end
            count_q <= count_q + CNT_W'(push) - CNT_W'(retire);
        end
    end

    // entry payload and captured flag updates
    always_ff @(posedge clk_i)
    begin
        for (int e = 0; e < DEPTH; e++)
        begin
            if (cdb_hit[e])
            begin
                upd_q[e] <= cdb_upd[e];
            end
        end
        if (push)
        begin
            entry_q[tail_q] <= dispatch_i;
            if (disp_hit)
            begin
                upd_q[tail_q] <= disp_upd;
            end
        end
    end

endmodule

// ==== rtl/exec_unit.sv ====
`timescale 1ns/1ps
`include "ooo_cfg.svh"

module exec_unit
#(
    parameter int LATENCY = 1
)
(
    input  logic             clk_i
    , input  logic           reset_i
    , input  ooo_pkg::issue_t issue_i
    , input  ooo_pkg::word_t src1_i
    , input  ooo_pkg::word_t src2_i
    , output ooo_pkg::cdb_t  cdb_o
);
    import ooo_pkg::*;

    logic [`OOO_WORD_SIZE:0] wide;
    word_t                   result;
    logic                    carry;
    logic                    overflow;
    flags_t                  flag_val;
    cdb_t                    next_entry;
    cdb_t                    pipe_q [LATENCY];

    always_comb
    begin
        wide     = '0;
        carry    = 1'b0;
        overflow = 1'b0;

        case (issue_i.op)
            ALU_ADD:
            begin
                wide     = {1'b0, src1_i} + {1'b0, src2_i};
                carry    = wide[`OOO_WORD_SIZE];
                overflow = (src1_i[`OOO_WORD_SIZE-1] == src2_i[`OOO_WORD_SIZE-1])
                    && (wide[`OOO_WORD_SIZE-1] != src1_i[`OOO_WORD_SIZE-1]);
            end
            // carry set means no borrow
            ALU_SUB:
            begin
                wide     = {1'b0, src1_i} + {1'b0, ~src2_i} + 1'b1;
                carry    = wide[`OOO_WORD_SIZE];
                overflow = (src1_i[`OOO_WORD_SIZE-1] != src2_i[`OOO_WORD_SIZE-1])
                    && (wide[`OOO_WORD_SIZE-1] != src1_i[`OOO_WORD_SIZE-1]);
            end
            ALU_AND:  wide = {1'b0, src1_i & src2_i};
            ALU_OR:   wide = {1'b0, src1_i | src2_i};
            ALU_XOR:  wide = {1'b0, src1_i ^ src2_i};
            default:  wide = {1'b0, src1_i};
        endcase

        result           = wide[`OOO_WORD_SIZE-1:0];
        flag_val         = '0;
        flag_val[FLAG_Z] = (result == '0);
        flag_val[FLAG_N] = result[`OOO_WORD_SIZE-1];
        flag_val[FLAG_C] = carry;
        flag_val[FLAG_V] = overflow;
    end

    always_comb
    begin
        next_entry.valid          = issue_i.valid;
        next_entry.dest           = issue_i.dest;
        next_entry.result         = result;
        next_entry.flag_upd.mask  = issue_i.flag_mask;
        next_entry.flag_upd.value = flag_val;
    end

    // stage 0 captures at the issue edge, the last stage drives the bus
    always_ff @(posedge clk_i)
    begin
        if (reset_i)
        begin
            for (int i = 0; i < LATENCY; i++)
            begin
                pipe_q[i].valid <= 1'b0;
            end
        end
        else
        begin
            pipe_q[0] <= next_entry;
            for (int i = 1; i < LATENCY; i++)
            begin
                pipe_q[i] <= pipe_q[i-1];
            end
        end
    end

    assign cdb_o = pipe_q[LATENCY-1];

endmodule

// ==== rtl/arch_state.sv ====
`timescale 1ns/1ps
`include "ooo_cfg.svh"

module arch_state
(
    input  logic                clk_i
    , input  logic              reset_i
    // one result per execution unit
    , input  ooo_pkg::cdb_t     cdb_i [`OOO_NUM_FU-1:0]
    // retirement from the commit queue
    , input  logic              commit_valid_i
    , input  ooo_pkg::preg_t    commit_free_i
    , input  ooo_pkg::preg_t    commit_set_i
    , input  logic              rollback_i
    , input  logic              flag_valid_i
    , input  ooo_pkg::flag_upd_t flag_upd_i
    , output ooo_pkg::flags_t   flags_o
    // issue read ports
    , input  ooo_pkg::preg_t    rs1_addr_i
    , output logic              rs1_valid_o
    , output ooo_pkg::word_t    rs1_data_o
    , input  ooo_pkg::preg_t    rs2_addr_i
    , output logic              rs2_valid_o
    , output ooo_pkg::word_t    rs2_data_o
);
    import ooo_pkg::*;

    // low registers start out valid
    localparam logic [`OOO_NUM_PHYS_REG-1:0] RESET_VALID =
        {`OOO_NUM_PHYS_REG{1'b1}} >> (`OOO_NUM_PHYS_REG - `OOO_NUM_ARCH_REG);

    word_t [`OOO_NUM_PHYS_REG-1:0] reg_q;
    word_t [`OOO_NUM_PHYS_REG-1:0] reg_n;
    logic [`OOO_NUM_PHYS_REG-1:0]  valid_spec_q;
    logic [`OOO_NUM_PHYS_REG-1:0]  valid_spec_n;
    logic [`OOO_NUM_PHYS_REG-1:0]  valid_arch_q;
    logic [`OOO_NUM_PHYS_REG-1:0]  valid_arch_n;
    flags_t                        flags_q;
    flags_t                        flags_n;

    assign flags_o = flags_q;

    // masked flag merge
    assign flags_n = flag_valid_i
        ? ((flag_upd_i.mask & flag_upd_i.value) | (~flag_upd_i.mask & flags_q))
        : flags_q;

    // read ports with bypass from the cdb
    always_comb
    begin
        rs1_valid_o = valid_spec_q[rs1_addr_i];
        rs1_data_o  = reg_q[rs1_addr_i];
        rs2_valid_o = valid_spec_q[rs2_addr_i];
        rs2_data_o  = reg_q[rs2_addr_i];

        for (int unsigned i = 0; i < `OOO_NUM_FU; i++)
        begin
            if (cdb_i[i].valid && cdb_i[i].dest == rs1_addr_i)
            begin
                rs1_valid_o = 1'b1;
                rs1_data_o  = cdb_i[i].result;
            end
            if (cdb_i[i].valid && cdb_i[i].dest == rs2_addr_i)
            begin
                rs2_valid_o = 1'b1;
                rs2_data_o  = cdb_i[i].result;
            end
        end
    end

    always_comb
    begin
        reg_n        = reg_q;
        valid_spec_n = valid_spec_q;
        valid_arch_n = valid_arch_q;

        // write back from the execution units
        for (int unsigned i = 0; i < `OOO_NUM_FU; i++)
        begin
            if (cdb_i[i].valid)
            begin
                reg_n[cdb_i[i].dest]        = cdb_i[i].result;
                valid_spec_n[cdb_i[i].dest] = 1'b1;
            end
        end

        // retire frees the old mapping and makes the new one architectural
        if (commit_valid_i)
        begin
            valid_spec_n[commit_free_i] = 1'b0;
            valid_arch_n[commit_free_i] = 1'b0;
            valid_arch_n[commit_set_i]  = 1'b1;
        end

        // squash everything speculative, keeping a same-cycle commit
        if (rollback_i)
        begin
            valid_spec_n = valid_arch_n;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (reset_i)
        begin
            reg_q        <= '0;
            valid_spec_q <= RESET_VALID;
            valid_arch_q <= RESET_VALID;
            flags_q      <= '0;
        end
        else
        begin
            reg_q        <= reg_n;
            valid_spec_q <= valid_spec_n;
            valid_arch_q <= valid_arch_n;
            flags_q      <= flags_n;
        end
    end

endmodule

// ==== rtl/ooo_pkg.sv ====
`include "ooo_cfg.svh"

package ooo_pkg;

    typedef logic [$clog2(`OOO_NUM_PHYS_REG)-1:0] preg_t;
    typedef logic [`OOO_WORD_SIZE-1:0]            word_t;
    typedef logic [`OOO_NUM_FLAGS-1:0]            flags_t;

    // bit positions inside flags_t
    localparam int FLAG_Z = 0;
    localparam int FLAG_N = 1;
    localparam int FLAG_C = 2;
    localparam int FLAG_V = 3;

    // masked flag write, mask sits in the upper half
    typedef struct packed {
        flags_t mask;
        flags_t value;
    } flag_upd_t;

    typedef struct packed {
        logic      valid;
        preg_t     dest;
        word_t     result;
        flag_upd_t flag_upd;
    } cdb_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS
    } alu_op_t;

    // operands come from the register file read ports
    typedef struct packed {
        logic    valid;
        alu_op_t op;
        preg_t   dest;
        flags_t  flag_mask;
    } issue_t;

    typedef struct packed {
        preg_t dest;
        preg_t old_dest;
    } dispatch_t;

endpackage

// ==== include/ooo_cfg.svh ====
`ifndef OOO_CFG_SVH
`define OOO_CFG_SVH

// execution units on the common data bus
`define OOO_NUM_FU 2

// physical register file size
`define OOO_NUM_PHYS_REG 32

// registers holding valid zero after reset
`define OOO_NUM_ARCH_REG 16

// data path width in bits
`define OOO_WORD_SIZE 32

// zero, negative, carry, overflow
`define OOO_NUM_FLAGS 4

// in-order retirement slots
`define OOO_CQ_DEPTH 8

`endif
